/* rd_port_stimulus.txt */
# hex columns: unlocal size, unlocal queue, two-hop size, two-hop queue, local size, local queue,
# relay sizes for queues 0 to 7, expected command count
100 1 200 2 300 3 0 0 0 0 0 0 0 0 3
40 5 0 0 80 6 0 0 0 0 0 0 0 0 2
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 10 20 30 40 50 60 70 80 8
0 0 0 0 0 0 0 0 0 1000 0 0 0 7 2
1 7 2 6 3 5 4 0 0 0 0 0 0 5 5
ffffffff 0 12345678 4 0 2 0 abc 0 0 def 0 0 0 4
0 3 20 1 0 0 1 0 0 0 0 0 0 0 2
800 2 0 0 0 0 0 0 0 0 0 0 0 0 1
64 4 128 5 256 6 1 2 3 4 5 6 7 8 b
0 0 0 0 7 1 0 0 ff 0 0 0 0 0 2

/* files.f */
rd_port_pkg.sv
pulse_sync.sv
direct_req_hold.sv
relay_queue_bank.sv
rd_phase_arbiter.sv
rd_cmd_issue.sv
rd_ddr_port_ctrl.sv
tb_rd_ddr_port_ctrl.sv

/* Makefile */
TOP := tb_rd_ddr_port_ctrl
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: PASS" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* tb_rd_ddr_port_ctrl.sv */
`timescale 1ns/1ps

module tb_rd_ddr_port_ctrl
    import rd_port_pkg::*;
();

    localparam int clk_half_ns       = 10;
    localparam int scen_bound_cycles = 800;

    logic        i_clk;
    logic        i_rst;
    byte_cnt_t   i_unlocal_size;
    queue_id_t   i_unlocal_queue;
    logic        i_unlocal_valid;
    byte_cnt_t   i_send_two_size;
    queue_id_t   i_send_two_queue;
    logic        i_send_two_valid;
    byte_cnt_t   i_local_size;
    queue_id_t   i_local_queue;
    logic        i_local_valid;
    relay_word_u i_tx_relay;
    logic        i_tx_relay_valid;
    logic        i_rd_byte_ready;
    logic        i_rd_queue_finish;
    logic        o_rd_flag;
    queue_id_t   o_rd_queue;
    byte_cnt_t   o_rd_byte;
    logic        o_rd_byte_valid;

    // Scenarios as read from the stimulus file
    byte_cnt_t   sc_unl_size[$];
    queue_id_t   sc_unl_q[$];
    byte_cnt_t   sc_two_size[$];
    queue_id_t   sc_two_q[$];
    byte_cnt_t   sc_loc_size[$];
    queue_id_t   sc_loc_q[$];
    relay_word_u sc_relay[$];
    int          sc_count[$];
    int          n_scen;

    // Commands still expected in the running scenario
    logic        exp_flag[$];
    queue_id_t   exp_queue[$];
    byte_cnt_t   exp_byte[$];

    int          cmd_cnt;
    int          err_cnt;
    int          check_cnt;
    logic        ddr_busy;
    logic        file_read_done;
    logic [15:0] lfsr;

    rd_ddr_port_ctrl #(.p_sync_stages(2)) dut_i (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_unlocal_size(i_unlocal_size), .i_unlocal_queue(i_unlocal_queue),
        .i_unlocal_valid(i_unlocal_valid),
        .i_send_two_size(i_send_two_size), .i_send_two_queue(i_send_two_queue),
        .i_send_two_valid(i_send_two_valid),
        .i_local_size(i_local_size), .i_local_queue(i_local_queue),
        .i_local_valid(i_local_valid),
        .i_tx_relay(i_tx_relay), .i_tx_relay_valid(i_tx_relay_valid),
        .i_rd_byte_ready(i_rd_byte_ready), .i_rd_queue_finish(i_rd_queue_finish),
        .o_rd_flag(o_rd_flag), .o_rd_queue(o_rd_queue), .o_rd_byte(o_rd_byte),
        .o_rd_byte_valid(o_rd_byte_valid)
    );

    always #(clk_half_ns) i_clk = ~i_clk;

    //////////////////////////////////////////////////////////////////////
    // Compare tasks and random bits
    //////////////////////////////////////////////////////////////////////

    task automatic check_byte(input string name, input byte_cnt_t got, input byte_cnt_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_queue(input string name, input queue_id_t got, input queue_id_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    // Command must not move while the DDR side holds off ready
    task automatic check_held(input logic flag, input queue_id_t q, input byte_cnt_t b);
        check_flag("o_rd_byte_valid", o_rd_byte_valid, 1'b1);
        check_flag("o_rd_flag", o_rd_flag, flag);
        check_queue("o_rd_queue", o_rd_queue, q);
        check_byte("o_rd_byte", o_rd_byte, b);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus file and expected command order
    //////////////////////////////////////////////////////////////////////

    task automatic read_stimulus();
        int          fd;
        int          code;
        int          line_no;
        string       line;
        logic [31:0] f [15];
        relay_word_u word;
        n_scen  = 0;
        line_no = 0;
        fd = $fopen("rd_port_stimulus.txt", "r");
        if (fd == 0) begin
            err_cnt++;
            $display("could not open rd_port_stimulus.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            line_no++;
            code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                           f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
            if (code == 15) begin
                sc_unl_size.push_back(f[0]);
                sc_unl_q.push_back(f[1][2:0]);
                sc_two_size.push_back(f[2]);
                sc_two_q.push_back(f[3][2:0]);
                sc_loc_size.push_back(f[4]);
                sc_loc_q.push_back(f[5][2:0]);
                for (int q = 0; q < queue_num; q++) begin
                    word.entry[q] = f[6 + q];
                end
                sc_relay.push_back(word);
                sc_count.push_back(int'(f[14]));
                n_scen++;
            end else if (code > 0) begin
                err_cnt++;
                $display("stimulus line %0d does not hold fifteen fields", line_no);
            end
        end
        $fclose(fd);
        if (n_scen == 0) begin
            err_cnt++;
            $display("no scenarios were read from rd_port_stimulus.txt");
        end
    endtask

    task automatic push_expected(input logic flag, input queue_id_t q, input byte_cnt_t b);
        exp_flag.push_back(flag);
        exp_queue.push_back(q);
        exp_byte.push_back(b);
    endtask

    // Unlocal, two-hop, local, then relay queues upward; zero sizes skipped
    task automatic build_expected(input int idx);
        relay_word_u word;
        word = sc_relay[idx];
        exp_flag.delete();
        exp_queue.delete();
        exp_byte.delete();
        if (sc_unl_size[idx] != '0) begin
            push_expected(1'b1, sc_unl_q[idx], sc_unl_size[idx]);
        end
        if (sc_two_size[idx] != '0) begin
            push_expected(1'b0, sc_two_q[idx], sc_two_size[idx]);
        end
        if (sc_loc_size[idx] != '0) begin
            push_expected(1'b0, sc_loc_q[idx], sc_loc_size[idx]);
        end
        for (int q = 0; q < queue_num; q++) begin
            if (word.entry[q] != '0) begin
                push_expected(1'b0, queue_id_t'(q), word.entry[q]);
            end
        end
    endtask

    task automatic run_scenario(input int idx);
        int err_before;
        int cycles;
        err_before = err_cnt;
        build_expected(idx);
        if (exp_byte.size() != sc_count[idx]) begin
            err_cnt++;
            $display("scenario %0d lists %0d commands but its requests give %0d",
                     idx, sc_count[idx], exp_byte.size());
        end
        cmd_cnt          = 0;
        i_unlocal_size   = sc_unl_size[idx];
        i_unlocal_queue  = sc_unl_q[idx];
        i_send_two_size  = sc_two_size[idx];
        i_send_two_queue = sc_two_q[idx];
        i_local_size     = sc_loc_size[idx];
        i_local_queue    = sc_loc_q[idx];
        i_tx_relay       = sc_relay[idx];
        i_unlocal_valid  = 1'b1;
        i_send_two_valid = 1'b1;
        i_local_valid    = 1'b1;
        i_tx_relay_valid = 1'b1;
        @(negedge i_clk);
        i_unlocal_valid  = 1'b0;
        i_send_two_valid = 1'b0;
        i_local_valid    = 1'b0;
        i_tx_relay_valid = 1'b0;
        // Arbiter back in idle ends the scenario
        cycles = 0;
        while ((dut_i.phase != ph_idle || ddr_busy) && cycles < scen_bound_cycles) begin
            @(negedge i_clk);
            cycles++;
        end
        if (cycles >= scen_bound_cycles) begin
            err_cnt++;
            $display("scenario %0d: arbiter did not return to idle within %0d cycles",
                     idx, scen_bound_cycles);
        end
        if (cmd_cnt != sc_count[idx]) begin
            err_cnt++;
            $display("scenario %0d: %0d commands seen where %0d were expected",
                     idx, cmd_cnt, sc_count[idx]);
        end
        $display("scenario %0d: %0d commands, %0d errors", idx, cmd_cnt, err_cnt - err_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // DDR side model
    //////////////////////////////////////////////////////////////////////

    initial begin : ddr_model
        int        wait_cyc;
        logic      cur_flag;
        queue_id_t cur_queue;
        byte_cnt_t cur_byte;
        i_rd_byte_ready   = 1'b0;
        i_rd_queue_finish = 1'b0;
        ddr_busy          = 1'b0;
        forever begin
            @(negedge i_clk);
            if (i_rst === 1'b0 && o_rd_byte_valid === 1'b1) begin
                ddr_busy  = 1'b1;
                cur_flag  = o_rd_flag;
                cur_queue = o_rd_queue;
                cur_byte  = o_rd_byte;
                cmd_cnt++;
                if (exp_byte.size() == 0) begin
                    err_cnt++;
                    $display("unexpected command for queue %0d with %0h bytes", cur_queue, cur_byte);
                end else begin
                    check_flag("o_rd_flag", cur_flag, exp_flag.pop_front());
                    check_queue("o_rd_queue", cur_queue, exp_queue.pop_front());
                    check_byte("o_rd_byte", cur_byte, exp_byte.pop_front());
                end
                take_bits(3, wait_cyc);
                repeat (wait_cyc + 1) begin
                    @(negedge i_clk);
                    check_held(cur_flag, cur_queue, cur_byte);
                end
                i_rd_byte_ready = 1'b1;
                while (o_rd_byte_valid === 1'b1) begin
                    @(negedge i_clk);
                    if (o_rd_byte_valid === 1'b1) begin
                        check_held(cur_flag, cur_queue, cur_byte);
                    end
                end
                i_rd_byte_ready   = 1'b0;
                i_rd_queue_finish = 1'b1;
                // Port still locked, so no new command yet
                repeat (2) begin
                    @(negedge i_clk);
                    check_flag("o_rd_byte_valid", o_rd_byte_valid, 1'b0);
                end
                i_rd_queue_finish = 1'b0;
                ddr_busy          = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (file_read_done === 1'b1);
        #((n_scen + 2) * scen_bound_cycles * 2 * clk_half_ns);
        $display("timeout: the run did not end within the time allowed for %0d scenarios", n_scen);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main
        i_clk            = 1'b0;
        i_rst            = 1'b1;
        i_unlocal_size   = '0;
        i_unlocal_queue  = '0;
        i_unlocal_valid  = 1'b0;
        i_send_two_size  = '0;
        i_send_two_queue = '0;
        i_send_two_valid = 1'b0;
        i_local_size     = '0;
        i_local_queue    = '0;
        i_local_valid    = 1'b0;
        i_tx_relay       = '0;
        i_tx_relay_valid = 1'b0;
        err_cnt          = 0;
        check_cnt        = 0;
        cmd_cnt          = 0;
        lfsr             = 16'd32522;
        file_read_done   = 1'b0;
        read_stimulus();
        file_read_done = 1'b1;
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        // Outputs quiet until the first unlocal strobe
        repeat (4) begin
            @(negedge i_clk);
            check_flag("o_rd_byte_valid", o_rd_byte_valid, 1'b0);
            check_flag("o_rd_flag", o_rd_flag, 1'b0);
            check_queue("o_rd_queue", o_rd_queue, '0);
            check_byte("o_rd_byte", o_rd_byte, '0);
        end
        for (int n = 0; n < n_scen; n++) begin
            run_scenario(n);
        end
        $display("scenarios %0d, checks %0d, errors %0d", n_scen, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* rd_ddr_port_ctrl.sv */
`timescale 1ns/1ps

module rd_ddr_port_ctrl
    import rd_port_pkg::*;
#(
    parameter int p_sync_stages = 2
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  byte_cnt_t   i_unlocal_size,
    input  queue_id_t   i_unlocal_queue,
    input  logic        i_unlocal_valid,
    input  byte_cnt_t   i_send_two_size,
    input  queue_id_t   i_send_two_queue,
    input  logic        i_send_two_valid,
    input  byte_cnt_t   i_local_size,
    input  queue_id_t   i_local_queue,
    input  logic        i_local_valid,
    input  relay_word_u i_tx_relay,
    input  logic        i_tx_relay_valid,
    input  logic        i_rd_byte_ready,
    input  logic        i_rd_queue_finish,
    output logic        o_rd_flag,
    output queue_id_t   o_rd_queue,
    output byte_cnt_t   o_rd_byte,
    output logic        o_rd_byte_valid
);

    logic      ready_pulse;
    logic      finish_pulse;
    byte_cnt_t unl_size, two_size, loc_size, head_size;
    queue_id_t unl_queue, two_queue, loc_queue, head_queue;
    logic      unl_valid, two_valid, loc_valid;
    logic      rel_unl, rel_two, rel_loc, rel_relay;
    logic      batch_valid, batch_empty, all_done, head_pending, head_done;
    rd_phase_e phase;
    logic      grant;
    byte_cnt_t sel_size;
    queue_id_t sel_queue;

    //////////////////////////////////////////////////////////////////////
    // DDR side strobes and request sources
    //////////////////////////////////////////////////////////////////////

    pulse_sync #(.p_sync_stages(p_sync_stages)) u_ready_sync (
        .i_clk(i_clk), .i_rst(i_rst), .i_level(i_rd_byte_ready), .o_pulse(ready_pulse)
    );
    pulse_sync #(.p_sync_stages(p_sync_stages)) u_finish_sync (
        .i_clk(i_clk), .i_rst(i_rst), .i_level(i_rd_queue_finish), .o_pulse(finish_pulse)
    );

    direct_req_hold u_unlocal_hold (
        .i_clk(i_clk), .i_rst(i_rst), .i_size(i_unlocal_size), .i_queue(i_unlocal_queue),
        .i_valid(i_unlocal_valid), .i_release(rel_unl),
        .o_size(unl_size), .o_queue(unl_queue), .o_valid(unl_valid)
    );
    direct_req_hold u_two_hold (
        .i_clk(i_clk), .i_rst(i_rst), .i_size(i_send_two_size), .i_queue(i_send_two_queue),
        .i_valid(i_send_two_valid), .i_release(rel_two),
        .o_size(two_size), .o_queue(two_queue), .o_valid(two_valid)
    );
    direct_req_hold u_local_hold (
        .i_clk(i_clk), .i_rst(i_rst), .i_size(i_local_size), .i_queue(i_local_queue),
        .i_valid(i_local_valid), .i_release(rel_loc),
        .o_size(loc_size), .o_queue(loc_queue), .o_valid(loc_valid)
    );

    relay_queue_bank u_relay_bank (
        .i_clk(i_clk), .i_rst(i_rst), .i_relay(i_tx_relay), .i_relay_valid(i_tx_relay_valid),
        .i_head_done(head_done), .i_release(rel_relay),
        .o_batch_valid(batch_valid), .o_batch_empty(batch_empty), .o_all_done(all_done),
        .o_head_queue(head_queue), .o_head_size(head_size), .o_head_pending(head_pending)
    );

    rd_phase_arbiter u_arbiter (
        .i_clk(i_clk), .i_rst(i_rst), .i_unlocal_strobe(i_unlocal_valid),
        .i_unlocal_valid(unl_valid), .i_unlocal_zero(unl_size == '0),
        .i_two_valid(two_valid), .i_two_zero(two_size == '0),
        .i_local_valid(loc_valid), .i_local_zero(loc_size == '0),
        .i_batch_valid(batch_valid), .i_batch_empty(batch_empty), .i_all_done(all_done),
        .i_finish(finish_pulse), .o_phase(phase),
        .o_release_unlocal(rel_unl), .o_release_two(rel_two), .o_release_local(rel_loc),
        .o_release_relay(rel_relay), .o_head_done(head_done)
    );

    // Granted source by phase, only with a nonzero request
    always_comb begin
        grant     = 1'b0;
        sel_size  = '0;
        sel_queue = '0;
        case (phase)
            ph_unlocal: begin
                grant     = unl_valid && (unl_size != '0);
                sel_size  = unl_size;
                sel_queue = unl_queue;
            end
            ph_own_two: begin
                grant     = two_valid && (two_size != '0);
                sel_size  = two_size;
                sel_queue = two_queue;
            end
            ph_local: begin
                grant     = loc_valid && (loc_size != '0);
                sel_size  = loc_size;
                sel_queue = loc_queue;
            end
            ph_relay: begin
                grant     = head_pending;
                sel_size  = head_size;
                sel_queue = head_queue;
            end
            default: grant = 1'b0;
        endcase
    end

    rd_cmd_issue u_issue (
        .i_clk(i_clk), .i_rst(i_rst), .i_phase(phase), .i_grant(grant),
        .i_size(sel_size), .i_queue(sel_queue), .i_ready(ready_pulse), .i_finish(finish_pulse),
        .o_rd_flag(o_rd_flag), .o_rd_queue(o_rd_queue), .o_rd_byte(o_rd_byte),
        .o_rd_byte_valid(o_rd_byte_valid)
    );

endmodule

/* rd_cmd_issue.sv */
`timescale 1ns/1ps

module rd_cmd_issue
    import rd_port_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  rd_phase_e i_phase,
    input  logic      i_grant,
    input  byte_cnt_t i_size,
    input  queue_id_t i_queue,
    input  logic      i_ready,
    input  logic      i_finish,
    output logic      o_rd_flag,
    output queue_id_t o_rd_queue,
    output byte_cnt_t o_rd_byte,
    output logic      o_rd_byte_valid
);

    logic      r_lock;
    logic      r_flag;
    queue_id_t r_queue;
    byte_cnt_t r_byte;
    logic      r_valid;
    logic      load;

    assign load = i_grant && !r_lock && (i_phase != ph_idle);

    // Port stays locked from issue until the queue finishes
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_lock <= 1'b0;
        end else if (i_finish) begin
            r_lock <= 1'b0;
        end else if (load) begin
            r_lock <= 1'b1;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_flag  <= 1'b0;
            r_queue <= '0;
            r_byte  <= '0;
            r_valid <= 1'b0;
        end else if (r_valid && i_ready) begin
            r_valid <= 1'b0;
        end else if (i_phase == ph_idle) begin
            r_flag  <= 1'b0;
            r_queue <= '0;
            r_byte  <= '0;
            r_valid <= 1'b0;
        end else if (load) begin
            r_flag  <= (i_phase == ph_unlocal);
            r_queue <= i_queue;
            r_byte  <= i_size;
            r_valid <= 1'b1;
        end
    end

    assign o_rd_flag       = r_flag;
    assign o_rd_queue      = r_queue;
    assign o_rd_byte       = r_byte;
    assign o_rd_byte_valid = r_valid;

endmodule

/* rd_phase_arbiter.sv */
`timescale 1ns/1ps

module rd_phase_arbiter
    import rd_port_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_unlocal_strobe,
    input  logic      i_unlocal_valid,
    input  logic      i_unlocal_zero,
    input  logic      i_two_valid,
    input  logic      i_two_zero,
    input  logic      i_local_valid,
    input  logic      i_local_zero,
    input  logic      i_batch_valid,
    input  logic      i_batch_empty,
    input  logic      i_all_done,
    input  logic      i_finish,
    output rd_phase_e o_phase,
    output logic      o_release_unlocal,
    output logic      o_release_two,
    output logic      o_release_local,
    output logic      o_release_relay,
    output logic      o_head_done
);

    rd_phase_e r_phase;
    rd_phase_e next_phase;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_phase <= ph_idle;
        end else begin
            r_phase <= next_phase;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Phase sequencing
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_phase = r_phase;
        case (r_phase)
            ph_idle: begin
                if (i_unlocal_strobe) begin
                    next_phase = ph_unlocal;
                end
            end
            ph_unlocal: begin
                if (i_finish || (i_unlocal_valid && i_unlocal_zero)) begin
                    next_phase = ph_own_two;
                end
            end
            ph_own_two: begin
                if (i_two_valid && (i_two_zero || i_finish)) begin
                    next_phase = ph_local;
                end
            end
            ph_local: begin
                if (i_local_valid && (i_local_zero || i_finish)) begin
                    next_phase = ph_relay;
                end
            end
            ph_relay: begin
                // Empty batch or every queue served
                if ((i_batch_valid && i_batch_empty) || i_all_done) begin
                    next_phase = ph_idle;
                end
            end
            default: next_phase = ph_idle;
        endcase
    end

    // Source released on the cycle its phase is left
    assign o_release_unlocal = (r_phase == ph_unlocal) && (next_phase != ph_unlocal);
    assign o_release_two     = (r_phase == ph_own_two) && (next_phase != ph_own_two);
    assign o_release_local   = (r_phase == ph_local) && (next_phase != ph_local);
    assign o_release_relay   = (r_phase == ph_relay) && (next_phase != ph_relay);

    assign o_head_done = (r_phase == ph_relay) && i_finish;
    assign o_phase     = r_phase;

endmodule

/* relay_queue_bank.sv */
`timescale 1ns/1ps

module relay_queue_bank
    import rd_port_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  relay_word_u i_relay,
    input  logic        i_relay_valid,
    input  logic        i_head_done,
    input  logic        i_release,
    output logic        o_batch_valid,
    output logic        o_batch_empty,
    output logic        o_all_done,
    output queue_id_t   o_head_queue,
    output byte_cnt_t   o_head_size,
    output logic        o_head_pending
);

    relay_word_u          r_word;
    logic                 r_batch_valid;
    logic                 r_load;
    logic                 r_loaded;
    logic [queue_num-1:0] r_pending;
    queue_id_t            head_q;

    always_ff @(posedge i_clk) begin
        if (!r_batch_valid && i_relay_valid) begin
            r_word <= i_relay;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Batch control and pending bits
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_batch_valid <= 1'b0;
            r_load        <= 1'b0;
            r_loaded      <= 1'b0;
            r_pending     <= '0;
        end else if (i_release) begin
            r_batch_valid <= 1'b0;
            r_load        <= 1'b0;
            r_loaded      <= 1'b0;
            r_pending     <= '0;
        end else begin
            r_load <= 1'b0;
            if (!r_batch_valid && i_relay_valid) begin
                r_batch_valid <= 1'b1;
                r_load        <= 1'b1;
            end
            if (r_load) begin
                r_loaded <= 1'b1;
                for (int q = 0; q < queue_num; q++) begin
                    r_pending[q] <= (r_word.entry[q] != '0);
                end
            end else if (i_head_done) begin
                r_pending[head_q] <= 1'b0;
            end
        end
    end

    // Lowest pending queue is the head
    always_comb begin
        head_q = '0;
        for (int q = queue_num - 1; q >= 0; q--) begin
            if (r_pending[q]) begin
                head_q = queue_id_t'(q);
            end
        end
    end

    assign o_batch_valid  = r_batch_valid;
    assign o_batch_empty  = r_batch_valid && (r_word.flat == '0);
    assign o_all_done     = r_loaded && (r_pending == '0);
    assign o_head_queue   = head_q;
    assign o_head_size    = r_word.entry[head_q];
    assign o_head_pending = |r_pending;

endmodule

/* direct_req_hold.sv */
`timescale 1ns/1ps

module direct_req_hold
    import rd_port_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  byte_cnt_t i_size,
    input  queue_id_t i_queue,
    input  logic      i_valid,
    input  logic      i_release,
    output byte_cnt_t o_size,
    output queue_id_t o_queue,
    output logic      o_valid
);

    byte_cnt_t r_size;
    queue_id_t r_queue;
    logic      r_valid;

    // Release wins over a new strobe in the same cycle
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_size  <= '0;
            r_queue <= '0;
            r_valid <= 1'b0;
        end else if (i_release) begin
            r_size  <= '0;
            r_queue <= '0;
            r_valid <= 1'b0;
        end else if (i_valid) begin
            r_size  <= i_size;
            r_queue <= i_queue;
            r_valid <= 1'b1;
        end
    end

    assign o_size  = r_size;
    assign o_queue = r_queue;
    assign o_valid = r_valid;

endmodule

/* pulse_sync.sv */
`timescale 1ns/1ps

module pulse_sync #(
    parameter int p_sync_stages = 2
) (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_level,
    output logic o_pulse
);

    // Sync stages plus one extra flop as the edge reference
    logic [p_sync_stages:0] r_sync;
    logic                   r_pulse;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_sync  <= '0;
            r_pulse <= 1'b0;
        end else begin
            r_sync  <= {r_sync[p_sync_stages-1:0], i_level};
            r_pulse <= r_sync[p_sync_stages-1] & ~r_sync[p_sync_stages];
        end
    end

    assign o_pulse = r_pulse;

endmodule

/* rd_port_pkg.sv */
package rd_port_pkg;

    localparam int byte_w    = 32;
    localparam int queue_num = 8;

    typedef logic [2:0]        queue_id_t;
    typedef logic [byte_w-1:0] byte_cnt_t;

    // One relay word, seen flat or per queue
    typedef union packed {
        logic [queue_num*byte_w-1:0] flat;
        byte_cnt_t [queue_num-1:0]   entry;
    } relay_word_u;

    // Read port phases, stepped in this order
    typedef enum logic [2:0] {
        ph_idle    = 3'd0,
        ph_unlocal = 3'd1,
        ph_own_two = 3'd2,
        ph_local   = 3'd3,
        ph_relay   = 3'd4
    } rd_phase_e;

endpackage
